//--- verilog/align_pkg.sv
package align_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Instruction and address width
  localparam int XLEN = 32;

  // One halfword, the size of a compressed instruction
  localparam int HALF_W = 16;

  //////////////////////////////
  // Buffer sizing
  //////////////////////////////

  // Response words held in the queue
  localparam int FIFO_DEPTH = 3;

  // Instruction counter, zero up to FIFO_DEPTH instructions
  localparam int FIFO_CNT_W = 3;

  // Outstanding request counter and flush counter
  localparam int OUTST_W = 2;
  localparam int MAX_OUTSTANDING = 2;

  //////////////////////////////
  // Encoding
  //////////////////////////////

  // Low two bits of a 32-bit instruction
  localparam logic [1:0] RVC_UNCOMP = 2'b11;

  // Byte step between consecutive fetch words
  localparam logic [XLEN-1:0] WORD_INCR = 32'd4;

  // True when the halfword starts a 16-bit instruction
  function automatic logic is_compressed(input logic [HALF_W-1:0] half);
    return (half[1:0] != RVC_UNCOMP);
  endfunction

endpackage

//--- verilog/align_resp_fifo.sv
`timescale 1ns/10ps

module align_resp_fifo (
  input  logic                      clk,
  input  logic                      rst_n,

  // Flush the whole queue
  input  logic                      kill_i,

  // Write side, one word per returned response
  input  logic                      push_i,
  input  logic [align_pkg::XLEN-1:0] push_rdata_i,
  input  logic                      push_err_i,

  // Head word fully consumed
  input  logic                      advance_i,

  // Read side, slot 0 and slot 1
  output logic                      head_valid_o,
  output logic [align_pkg::XLEN-1:0] head_rdata_o,
  output logic                      head_err_o,
  output logic                      next_valid_o,
  output logic [align_pkg::XLEN-1:0] next_rdata_o,
  output logic                      next_err_o
);

  // Slot 0 is the head of the queue
  logic [align_pkg::XLEN-1:0] rdata_q   [align_pkg::FIFO_DEPTH];
  logic [align_pkg::XLEN-1:0] rdata_int [align_pkg::FIFO_DEPTH];
  logic [align_pkg::XLEN-1:0] rdata_n   [align_pkg::FIFO_DEPTH];
  logic                       err_q     [align_pkg::FIFO_DEPTH];
  logic                       err_int   [align_pkg::FIFO_DEPTH];
  logic                       err_n     [align_pkg::FIFO_DEPTH];
  logic [align_pkg::FIFO_DEPTH-1:0] valid_q, valid_int, valid_n;

  // Set once the incoming word has found its slot
  logic placed;

  // Push goes into the lowest empty slot
  always_comb begin
    rdata_int = rdata_q;
    err_int   = err_q;
    valid_int = valid_q;
    placed    = 1'b0;
    for (int i = 0; i < align_pkg::FIFO_DEPTH; i++) begin
      if (push_i && !placed && !valid_q[i]) begin
        rdata_int[i] = push_rdata_i;
        err_int[i]   = push_err_i;
        valid_int[i] = 1'b1;
        placed       = 1'b1;
      end
    end
  end

  // Shift down one slot after the push, top slot empties
  always_comb begin
    rdata_n = rdata_int;
    err_n   = err_int;
    valid_n = valid_int;
    if (advance_i) begin
      for (int i = 0; i < align_pkg::FIFO_DEPTH - 1; i++) begin
        rdata_n[i] = rdata_int[i+1];
        err_n[i]   = err_int[i+1];
        valid_n[i] = valid_int[i+1];
      end
      valid_n[align_pkg::FIFO_DEPTH-1] = 1'b0;
    end
  end

  // Valid bits, kill empties the queue
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (kill_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_n;
    end
  end

  // Word payload
  always_ff @(posedge clk) begin
    rdata_q <= rdata_n;
    err_q   <= err_n;
  end

  assign head_valid_o = valid_q[0];
  assign head_rdata_o = rdata_q[0];
  assign head_err_o   = err_q[0];
  assign next_valid_o = valid_q[1];
  assign next_rdata_o = rdata_q[1];
  assign next_err_o   = err_q[1];

endmodule

//--- verilog/align_extract.sv
`timescale 1ns/10ps

module align_extract (
  input  logic                       clk,
  input  logic                       rst_n,

  // Branch control
  input  logic                       pc_set_i,
  input  logic                       kill_i,
  input  logic [align_pkg::XLEN-1:0] branch_addr_i,

  // Incoming response, already gated by the flush counter
  input  logic                       resp_push_i,
  input  logic [align_pkg::XLEN-1:0] resp_rdata_i,
  input  logic                       resp_err_i,

  // Queue slots 0 and 1
  input  logic                       head_valid_i,
  input  logic [align_pkg::XLEN-1:0] head_rdata_i,
  input  logic                       head_err_i,
  input  logic                       next_valid_i,
  input  logic [align_pkg::XLEN-1:0] next_rdata_i,
  input  logic                       next_err_i,

  // Decode side
  input  logic                       instr_ready_i,
  output logic                       instr_valid_o,
  output logic [align_pkg::XLEN-1:0] instr_rdata_o,
  output logic                       instr_err_o,
  output logic [align_pkg::XLEN-1:0] instr_addr_o,

  // To queue and control
  output logic                       advance_o,
  output logic                       issue_o
);

  localparam int HW = align_pkg::HALF_W;

  logic [align_pkg::XLEN-1:0] addr_q, addr_n, addr_incr;

  // First word holding the instruction, and the word after it
  logic [align_pkg::XLEN-1:0] word, second;
  logic                       word_err, second_err;
  logic [align_pkg::XLEN-1:0] instr_unaligned;
  logic                       err_unaligned;

  logic valid_any, valid_unaligned_uncomp;
  logic aligned_is_comp, unaligned_is_comp;

  //////////////////////////////
  // Source selection
  //////////////////////////////

  // Head slot wins, otherwise the word on the response bus
  assign word     = head_valid_i ? head_rdata_i : resp_rdata_i;
  assign word_err = head_valid_i ? head_err_i   : resp_err_i;

  // Second half of a split instruction comes from slot 1 or the bus
  assign second     = next_valid_i ? next_rdata_i : resp_rdata_i;
  assign second_err = next_valid_i ? next_err_i   : resp_err_i;

  // Upper half of the first word joined with the lower half of the next
  assign instr_unaligned = {second[HW-1:0], word[align_pkg::XLEN-1:HW]};

  assign aligned_is_comp   = align_pkg::is_compressed(word[HW-1:0]);
  assign unaligned_is_comp = align_pkg::is_compressed(word[align_pkg::XLEN-1:HW]);

  // A split 32-bit instruction also carries the error of its second word
  assign err_unaligned = word_err | (!unaligned_is_comp & second_err);

  // Some data is available at all
  assign valid_any = head_valid_i | resp_push_i;

  // Both halves present, slot 1 implies slot 0
  assign valid_unaligned_uncomp = next_valid_i | (head_valid_i & resp_push_i);

  //////////////////////////////
  // Output instruction
  //////////////////////////////

  always_comb begin
    instr_rdata_o = word;
    instr_err_o   = word_err;
    instr_valid_o = 1'b0;
    if (kill_i) begin
      // Buffer contents are being thrown away
      instr_valid_o = 1'b0;
    end else if (addr_q[1]) begin
      instr_rdata_o = instr_unaligned;
      instr_err_o   = err_unaligned;
      if (!valid_any) begin
        instr_valid_o = 1'b0;
      end else if (unaligned_is_comp) begin
        // Only the upper half of the first word is needed
        instr_valid_o = 1'b1;
      end else begin
        instr_valid_o = valid_unaligned_uncomp;
      end
    end else begin
      // Aligned, whole instruction lives in one word
      instr_valid_o = valid_any;
    end
  end

  assign issue_o = instr_valid_o & instr_ready_i;

  //////////////////////////////
  // Address tracking
  //////////////////////////////

  // Start of the following word
  assign addr_incr = {addr_q[align_pkg::XLEN-1:2], 2'b00} + align_pkg::WORD_INCR;

  always_comb begin
    addr_n    = addr_q;
    advance_o = 1'b0;
    if (issue_o) begin
      if (addr_q[1]) begin
        // Upper half always ends the head word
        advance_o = 1'b1;
        if (unaligned_is_comp) begin
          addr_n = {addr_incr[align_pkg::XLEN-1:2], 2'b00};
        end else begin
          // Split instruction ends in the lower half of the next word
          addr_n = {addr_incr[align_pkg::XLEN-1:2], 2'b10};
        end
      end else if (aligned_is_comp) begin
        // Stay in this word, move to its upper half
        addr_n = {addr_q[align_pkg::XLEN-1:2], 2'b10};
      end else begin
        advance_o = 1'b1;
        addr_n    = {addr_incr[align_pkg::XLEN-1:2], 2'b00};
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (pc_set_i) begin
      // Target belongs to the first word returned after the branch
      addr_q <= branch_addr_i;
    end else begin
      addr_q <= addr_n;
    end
  end

  assign instr_addr_o = addr_q;

endmodule

//--- verilog/align_fetch_ctrl.sv
`timescale 1ns/10ps

module align_fetch_ctrl (
  input  logic                       clk,
  input  logic                       rst_n,

  // External control
  input  logic                       instr_req_i,
  input  logic                       pc_set_i,
  input  logic                       kill_i,
  input  logic [align_pkg::XLEN-1:0] branch_addr_i,

  // Fetch request handshake
  input  logic                       fetch_ready_i,
  output logic                       fetch_valid_o,

  // Response channel, no back-pressure
  input  logic                       resp_valid_i,
  input  logic [align_pkg::XLEN-1:0] resp_rdata_i,

  // Instruction consumed downstream
  input  logic                       issue_i,

  // Response accepted into the buffer
  output logic                       resp_push_o
);

  localparam int HW = align_pkg::HALF_W;
  localparam int CW = align_pkg::FIFO_CNT_W;
  localparam int OW = align_pkg::OUTST_W;

  // Complete instructions held in queue plus bus
  logic [CW-1:0] instr_cnt_q, instr_cnt_n;

  // Complete instructions that the incoming word adds
  logic [CW-1:0] n_incoming;

  // Requests accepted but not yet answered
  logic [OW-1:0] outst_cnt_q, outst_cnt_n;
  logic          outst_up, outst_down;

  // Stale responses still to drop after a branch
  logic [OW-1:0] flush_cnt_q, flush_cnt_n, flush_branch;

  // Parse state of the write side
  // aligned=0 with complete=1 only follows an unaligned branch
  logic aligned_q, aligned_n;
  logic complete_q, complete_n;

  logic lo_comp, hi_comp;

  // Drop responses that belong to the old path
  assign resp_push_o = (flush_cnt_q == '0) ? resp_valid_i : 1'b0;

  //////////////////////////////
  // Fetch request
  //////////////////////////////

  // Ask for more while the buffer runs low, or always on a branch
  assign fetch_valid_o = instr_req_i &&
                         (outst_cnt_q < align_pkg::MAX_OUTSTANDING) &&
                         ((instr_cnt_q == '0) ||
                          (instr_cnt_q == CW'(1) && outst_cnt_q == '0) ||
                          pc_set_i);

  //////////////////////////////
  // Word parsing
  //////////////////////////////

  assign lo_comp = align_pkg::is_compressed(resp_rdata_i[HW-1:0]);
  assign hi_comp = align_pkg::is_compressed(resp_rdata_i[align_pkg::XLEN-1:HW]);

  always_comb begin
    aligned_n  = aligned_q;
    complete_n = complete_q;
    n_incoming = '0;
    if (pc_set_i) begin
      // Branch target decides where parsing starts
      aligned_n  = !branch_addr_i[1];
      complete_n = branch_addr_i[1];
    end else if (resp_push_o) begin
      if (aligned_q && !lo_comp) begin
        // One full 32-bit instruction, state unchanged
        n_incoming = CW'(1);
      end else if (aligned_q || !complete_q) begin
        // Lower half ends an instruction, either a compressed one or the
        // tail of a split one
        if (hi_comp) begin
          n_incoming = CW'(2);
          aligned_n  = 1'b1;
          complete_n = 1'b1;
        end else begin
          // Upper half opens a split instruction
          n_incoming = CW'(1);
          aligned_n  = 1'b0;
          complete_n = 1'b0;
        end
      end else begin
        // First word after an unaligned branch, lower half is skipped
        if (hi_comp) begin
          n_incoming = CW'(1);
          aligned_n  = 1'b1;
          complete_n = 1'b1;
        end else begin
          aligned_n  = 1'b0;
          complete_n = 1'b0;
        end
      end
    end
  end

  // Instruction count, issues subtract one
  always_comb begin
    if (kill_i) begin
      instr_cnt_n = '0;
    end else if (issue_i) begin
      instr_cnt_n = instr_cnt_q + n_incoming - CW'(1);
    end else begin
      instr_cnt_n = instr_cnt_q + n_incoming;
    end
  end

  //////////////////////////////
  // Outstanding and flush
  //////////////////////////////

  assign outst_up   = fetch_valid_o & fetch_ready_i;
  assign outst_down = resp_valid_i;

  always_comb begin
    outst_cnt_n = outst_cnt_q;
    if (outst_up && !outst_down) begin
      outst_cnt_n = outst_cnt_q + OW'(1);
    end else if (!outst_up && outst_down) begin
      outst_cnt_n = outst_cnt_q - OW'(1);
    end
  end

  // A response in the branch cycle itself is no longer pending
  assign flush_branch = resp_valid_i ? (outst_cnt_q - OW'(1)) : outst_cnt_q;

  always_comb begin
    flush_cnt_n = flush_cnt_q;
    if (pc_set_i) begin
      flush_cnt_n = flush_branch;
    end else if (resp_valid_i && (flush_cnt_q != '0)) begin
      flush_cnt_n = flush_cnt_q - OW'(1);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_cnt_q <= '0;
      outst_cnt_q <= '0;
      flush_cnt_q <= '0;
      aligned_q   <= 1'b0;
      complete_q  <= 1'b0;
    end else begin
      instr_cnt_q <= instr_cnt_n;
      outst_cnt_q <= outst_cnt_n;
      flush_cnt_q <= flush_cnt_n;
      aligned_q   <= aligned_n;
      complete_q  <= complete_n;
    end
  end

endmodule

//--- verilog/align_buffer_top.sv
`timescale 1ns/10ps

module align_buffer_top (
  input  logic                       clk,
  input  logic                       rst_n,

  // Control from the core
  input  logic                       instr_req_i,
  input  logic                       pc_set_i,
  input  logic                       kill_i,
  input  logic [align_pkg::XLEN-1:0] branch_addr_i,

  // Prefetcher request side
  output logic                       fetch_valid_o,
  input  logic                       fetch_ready_i,
  output logic                       fetch_branch_o,
  output logic [align_pkg::XLEN-1:0] fetch_branch_addr_o,

  // Prefetcher response side
  input  logic                       resp_valid_i,
  input  logic [align_pkg::XLEN-1:0] resp_rdata_i,
  input  logic                       resp_err_i,

  // Decode side
  output logic                       instr_valid_o,
  input  logic                       instr_ready_i,
  output logic [align_pkg::XLEN-1:0] instr_rdata_o,
  output logic                       instr_err_o,
  output logic [align_pkg::XLEN-1:0] instr_addr_o
);

  logic                       resp_push;
  logic                       advance;
  logic                       issue;
  logic                       head_valid, next_valid;
  logic [align_pkg::XLEN-1:0] head_rdata, next_rdata;
  logic                       head_err, next_err;

  // Prefetcher restarts at the word holding the target
  assign fetch_branch_o      = pc_set_i;
  assign fetch_branch_addr_o = {branch_addr_i[align_pkg::XLEN-1:2], 2'b00};

  align_fetch_ctrl u_fetch_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_req_i   (instr_req_i),
    .pc_set_i      (pc_set_i),
    .kill_i        (kill_i),
    .branch_addr_i (branch_addr_i),
    .fetch_ready_i (fetch_ready_i),
    .fetch_valid_o (fetch_valid_o),
    .resp_valid_i  (resp_valid_i),
    .resp_rdata_i  (resp_rdata_i),
    .issue_i       (issue),
    .resp_push_o   (resp_push)
  );

  align_resp_fifo u_resp_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .kill_i       (kill_i),
    .push_i       (resp_push),
    .push_rdata_i (resp_rdata_i),
    .push_err_i   (resp_err_i),
    .advance_i    (advance),
    .head_valid_o (head_valid),
    .head_rdata_o (head_rdata),
    .head_err_o   (head_err),
    .next_valid_o (next_valid),
    .next_rdata_o (next_rdata),
    .next_err_o   (next_err)
  );

  align_extract u_extract (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_set_i      (pc_set_i),
    .kill_i        (kill_i),
    .branch_addr_i (branch_addr_i),
    .resp_push_i   (resp_push),
    .resp_rdata_i  (resp_rdata_i),
    .resp_err_i    (resp_err_i),
    .head_valid_i  (head_valid),
    .head_rdata_i  (head_rdata),
    .head_err_i    (head_err),
    .next_valid_i  (next_valid),
    .next_rdata_i  (next_rdata),
    .next_err_i    (next_err),
    .instr_ready_i (instr_ready_i),
    .instr_valid_o (instr_valid_o),
    .instr_rdata_o (instr_rdata_o),
    .instr_err_o   (instr_err_o),
    .instr_addr_o  (instr_addr_o),
    .advance_o     (advance),
    .issue_o       (issue)
  );

endmodule

//--- dv/imem_responder.sv
`timescale 1ns/10ps

module imem_responder (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        fetch_valid_i,
  output logic        fetch_ready_o,
  input  logic        fetch_branch_i,
  input  logic [31:0] fetch_branch_addr_i,
  output logic        resp_valid_o,
  output logic [31:0] resp_rdata_o,
  output logic        resp_err_o
);

  // Words at 0x00..0x1f, error flags at 0x20..0x3f
  logic [31:0] image [0:255];

  // Accepted word addresses, oldest first
  logic [31:0] pend_q [$];
  logic [31:0] next_addr;
  logic [31:0] addr_now;
  logic [31:0] resp_addr;
  int          wait_left;

  initial begin
    for (int i = 0; i < 256; i++) begin
      image[i] = 32'h0000_0003 | (i << 8) | (i << 20);
    end
    $readmemh("dv/align_testdata.txt", image);
    fetch_ready_o = 1'b0;
    resp_valid_o  = 1'b0;
    resp_rdata_o  = '0;
    resp_err_o    = 1'b0;
    wait_left     = 0;
  end

  // Accepted requests, branch restarts the word address
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q.delete();
      next_addr = '0;
    end else begin
      addr_now = fetch_branch_i ? fetch_branch_addr_i : next_addr;
      if (fetch_valid_i && fetch_ready_o) begin
        pend_q.push_back(addr_now);
        next_addr = addr_now + 32'd4;
      end else begin
        next_addr = addr_now;
      end
    end
  end

  // Ready and responses change on the falling edge
  always @(negedge clk) begin
    resp_valid_o = 1'b0;
    if (!rst_n) begin
      fetch_ready_o = 1'b0;
      wait_left     = 0;
    end else begin
      fetch_ready_o = ($urandom_range(0, 3) != 0);
      if (pend_q.size() > 0) begin
        // Head waits 1 to 3 cycles
        if (wait_left == 0) begin
          wait_left = $urandom_range(1, 3);
        end
        wait_left--;
        if (wait_left == 0) begin
          resp_addr    = pend_q.pop_front();
          resp_valid_o = 1'b1;
          resp_rdata_o = image[resp_addr[6:2]];
          resp_err_o   = image[32 + resp_addr[6:2]][0];
        end
      end
    end
  end

endmodule

//--- dv/align_buffer_tb.sv
`timescale 1ns/10ps

module align_buffer_tb;

  logic        clk;
  logic        rst_n;
  logic        instr_req_i;
  logic        pc_set_i;
  logic        kill_i;
  logic [31:0] branch_addr_i;
  logic        fetch_valid_o;
  logic        fetch_ready_i;
  logic        fetch_branch_o;
  logic [31:0] fetch_branch_addr_o;
  logic        resp_valid_i;
  logic [31:0] resp_rdata_i;
  logic        resp_err_i;
  logic        instr_valid_o;
  logic        instr_ready_i;
  logic [31:0] instr_rdata_o;
  logic        instr_err_o;
  logic [31:0] instr_addr_o;

  // Scenario table and expected stream
  logic [31:0] tdata [0:255];
  logic [31:0] scen_target [0:15];
  int          scen_count [0:15];
  int          scen_redirect [0:15];
  int          n_scen;
  logic [31:0] exp_addr [$];
  logic [31:0] exp_instr [$];
  logic        exp_err [$];
  int          total;
  bit          parsed;

  int exp_idx;
  int exp_end;
  int errors;
  int checks;

  // Output state seen at the last stalled edge
  bit          stalled_q;
  logic [31:0] held_addr;
  logic [31:0] held_rdata;
  logic        held_err;

  align_buffer_top u_align_buffer_top (
    .clk                 (clk),
    .rst_n               (rst_n),
    .instr_req_i         (instr_req_i),
    .pc_set_i            (pc_set_i),
    .kill_i              (kill_i),
    .branch_addr_i       (branch_addr_i),
    .fetch_valid_o       (fetch_valid_o),
    .fetch_ready_i       (fetch_ready_i),
    .fetch_branch_o      (fetch_branch_o),
    .fetch_branch_addr_o (fetch_branch_addr_o),
    .resp_valid_i        (resp_valid_i),
    .resp_rdata_i        (resp_rdata_i),
    .resp_err_i          (resp_err_i),
    .instr_valid_o       (instr_valid_o),
    .instr_ready_i       (instr_ready_i),
    .instr_rdata_o       (instr_rdata_o),
    .instr_err_o         (instr_err_o),
    .instr_addr_o        (instr_addr_o)
  );

  imem_responder u_imem (
    .clk                 (clk),
    .rst_n               (rst_n),
    .fetch_valid_i       (fetch_valid_o),
    .fetch_ready_o       (fetch_ready_i),
    .fetch_branch_i      (fetch_branch_o),
    .fetch_branch_addr_i (fetch_branch_addr_o),
    .resp_valid_o        (resp_valid_i),
    .resp_rdata_o        (resp_rdata_i),
    .resp_err_o          (resp_err_i)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Compressed instructions only carry their low halfword
  function automatic logic [31:0] compare_mask(input logic [31:0] instr);
    return (instr[1:0] != 2'b11) ? 32'h0000_ffff : 32'hffff_ffff;
  endfunction

  task automatic print_summary();
    $display("Summary: %0d instructions checked, %0d errors", checks, errors);
  endtask

  //////////////////////////////
  // Output checking
  //////////////////////////////

  task automatic check_issue();
    logic [31:0] mask;
    if (exp_idx >= exp_end) begin
      $display("Extra instruction issued at %0t from address %h", $time, instr_addr_o);
      errors++;
    end else begin
      mask = compare_mask(exp_instr[exp_idx]);
      if (instr_addr_o !== exp_addr[exp_idx]) begin
        $display("mismatch at %0t: instr_addr_o expected %h actual %h",
                 $time, exp_addr[exp_idx], instr_addr_o);
        errors++;
      end
      if ((instr_rdata_o & mask) !== (exp_instr[exp_idx] & mask)) begin
        $display("mismatch at %0t: instr_rdata_o expected %h actual %h",
                 $time, exp_instr[exp_idx] & mask, instr_rdata_o & mask);
        errors++;
      end
      if (instr_err_o !== exp_err[exp_idx]) begin
        $display("mismatch at %0t: instr_err_o expected %b actual %b",
                 $time, exp_err[exp_idx], instr_err_o);
        errors++;
      end
      checks++;
      exp_idx++;
    end
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      // Prefetcher redirect follows the branch input
      if (fetch_branch_o !== pc_set_i) begin
        $display("mismatch at %0t: fetch_branch_o expected %b actual %b",
                 $time, pc_set_i, fetch_branch_o);
        errors++;
      end
      // Redirect address is the word holding the target
      if (pc_set_i && (fetch_branch_addr_o !== (branch_addr_i & 32'hffff_fffc))) begin
        $display("mismatch at %0t: fetch_branch_addr_o expected %h actual %h",
                 $time, branch_addr_i & 32'hffff_fffc, fetch_branch_addr_o);
        errors++;
      end
      // No request while fetching is off
      if (!instr_req_i && (fetch_valid_o !== 1'b0)) begin
        $display("mismatch at %0t: fetch_valid_o expected 0 actual %b",
                 $time, fetch_valid_o);
        errors++;
      end
      // Stalled output must stay put unless a kill drops it
      if (stalled_q && !kill_i) begin
        if (instr_valid_o !== 1'b1) begin
          $display("Instruction at %h withdrawn while stalled at %0t", held_addr, $time);
          errors++;
        end else begin
          if (instr_addr_o !== held_addr) begin
            $display("mismatch at %0t: instr_addr_o expected %h actual %h",
                     $time, held_addr, instr_addr_o);
            errors++;
          end
          if ((instr_rdata_o & compare_mask(held_rdata)) !==
              (held_rdata & compare_mask(held_rdata))) begin
            $display("mismatch at %0t: instr_rdata_o expected %h actual %h",
                     $time, held_rdata, instr_rdata_o);
            errors++;
          end
          if (instr_err_o !== held_err) begin
            $display("mismatch at %0t: instr_err_o expected %b actual %b",
                     $time, held_err, instr_err_o);
            errors++;
          end
        end
      end
      stalled_q  = instr_valid_o && !instr_ready_i;
      held_addr  = instr_addr_o;
      held_rdata = instr_rdata_o;
      held_err   = instr_err_o;
      if (instr_valid_o && instr_ready_i) begin
        check_issue();
      end
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // Branch and kill for one cycle, fetching stays on
  task automatic do_branch(input logic [31:0] target);
    pc_set_i      = 1'b1;
    kill_i        = 1'b1;
    branch_addr_i = target;
    instr_req_i   = 1'b1;
    instr_ready_i = 1'b0;
    @(negedge clk);
    pc_set_i = 1'b0;
    kill_i   = 1'b0;
  endtask

  initial begin
    int ptr;
    void'($urandom(32'h693fade3));
    rst_n         = 1'b0;
    instr_req_i   = 1'b0;
    pc_set_i      = 1'b0;
    kill_i        = 1'b0;
    branch_addr_i = '0;
    instr_ready_i = 1'b0;
    errors        = 0;
    checks        = 0;
    exp_idx       = 0;
    exp_end       = 0;
    total         = 0;
    stalled_q     = 1'b0;

    // Scenario area starts at word 0x40
    $readmemh("dv/align_testdata.txt", tdata);
    ptr    = 'h40;
    n_scen = tdata[ptr];
    ptr++;
    for (int s = 0; s < n_scen; s++) begin
      scen_target[s]   = tdata[ptr];
      scen_count[s]    = tdata[ptr+1];
      scen_redirect[s] = tdata[ptr+2];
      ptr += 3;
      for (int k = 0; k < scen_count[s]; k++) begin
        exp_addr.push_back(tdata[ptr]);
        exp_instr.push_back(tdata[ptr+1]);
        exp_err.push_back(tdata[ptr+2][0]);
        ptr += 3;
      end
      total += scen_count[s];
    end
    parsed = 1'b1;

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // Nothing buffered before the first branch
    if (instr_valid_o !== 1'b0) begin
      $display("mismatch at %0t: instr_valid_o expected 0 actual %b",
               $time, instr_valid_o);
      errors++;
    end

    for (int s = 0; s < n_scen; s++) begin
      exp_end = exp_idx + scen_count[s];
      do_branch(scen_target[s]);
      forever begin
        @(negedge clk);
        if (exp_idx >= exp_end) break;
        instr_ready_i = ($urandom_range(0, 3) != 0);
      end
      instr_ready_i = 1'b0;
      if (scen_redirect[s] == 0) begin
        // Let the old path drain before the next branch
        instr_req_i = 1'b0;
        repeat (6) @(negedge clk);
      end
    end

    repeat (4) @(negedge clk);
    print_summary();
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Watchdog scaled to the expected stream length
  initial begin
    wait (parsed);
    repeat (total * 40 + 20) @(posedge clk);
    $display("Timeout, only %0d of %0d expected instructions were issued", exp_idx, total);
    errors++;
    print_summary();
    $display("Done: errors found");
    $finish;
  end

endmodule

//--- project.f
verilog/align_pkg.sv
verilog/align_resp_fifo.sv
verilog/align_extract.sv
verilog/align_fetch_ctrl.sv
verilog/align_buffer_top.sv
dv/imem_responder.sv
dv/align_buffer_tb.sv

//--- dv/align_testdata.txt
// @00 instruction words, @20 error flag per word, @40 scenario count
// Scenario: target count redirect, then one line per instruction: addr instr err
@00
00100093 00200113 00300193 00400213
05134501 050500a0 00b00593 06138082
460500c0 00d00693 00e00713 07934705
478500f0 01000813 00000013 00000013
00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013
@20
0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
@40
6
00000000 2 1
00000000 00100093 0
00000004 00200113 0
00000028 5 0
00000028 00e00713 0
0000002c 00004705 0
0000002e 00f00793 1
00000032 00004785 1
00000034 01000813 0
00000000 4 0
00000000 00100093 0
00000004 00200113 0
00000008 00300193 0
0000000c 00400213 0
00000010 8 0
00000010 00004501 0
00000012 00a00513 0
00000016 00000505 0
00000018 00b00593 0
0000001c 00008082 0
0000001e 00c00613 0
00000022 00004605 0
00000024 00d00693 0
00000016 3 1
00000016 00000505 0
00000018 00b00593 0
0000001c 00008082 0
00000012 4 0
00000012 00a00513 0
00000016 00000505 0
00000018 00b00593 0
0000001c 00008082 0
